/* tests/cache_stim.txt */
// Columns in hex: op adr dat sel tag expected_read_data
// op 0 read, 1 write, 10/11 same with no gap after, 2 sweep of dat lines from adr, ff end
// Unwritten addresses read as zero.
0 00000100 00000000 f 01 00000000
0 00000204 00000000 3 02 00000000
// Full and partial reads of one written word.
1 00000300 a1b2c3d4 f 03 00000000
0 00000300 00000000 f 04 a1b2c3d4
0 00000300 00000000 5 05 00b200d4
0 00000300 00000000 a 06 a100c300
// Byte merge over three writes.
1 00000408 11223344 f 07 00000000
1 00000408 aabbccdd 6 08 00000000
1 00000408 55667788 1 09 00000000
0 00000408 00000000 f 0a 11bbcc88
// Forty lines, more than the cache holds.
2 00001000 00000028 0 00 00000000
// Back-to-back burst over new lines.
11 00000600 0badf00d f 10 00000000
10 00000610 00000000 f 11 00000000
11 00000620 cafe0001 3 12 00000000
10 00000600 00000000 f 13 0badf00d
11 00000630 12345678 c 14 00000000
10 00000620 00000000 f 15 00000001
10 00000630 00000000 f 16 12340000
0 00000640 00000000 f 17 00000000
// Mixed traffic with random gaps.
1 00002000 deadbeef f 20 00000000
1 00002004 01234567 f 21 00000000
0 00002000 00000000 c 22 dead0000
1 00003ff0 fedcba98 f 23 00000000
1 00002004 ffffffff 2 24 00000000
0 00002004 00000000 f 25 0123ff67
0 00003ff0 00000000 3 26 0000ba98
0 0000200c 00000000 f 27 00000000
1 0000300c 80000001 9 28 00000000
0 0000300c 00000000 f 29 80000001
0 00002000 00000000 f 2a deadbeef
ff 00000000 00000000 0 00 00000000

/* files.f */
common/cache_pkg.sv
common/bus_pkg.sv
cache/req_fifo.sv
cache/lru_tracker.sv
cache/line_cache.sv
design/line_store.sv
design/cache_top.sv
tests/tb_clock.sv
tests/cache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the cache testbench with Verilator and runs it from the project root.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module cache_tb \
    -f files.f -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vcache_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  exit 1
fi
exit 0

/* tests/cache_tb.sv */
`timescale 1ns/1ns

module cache_tb
  import bus_pkg::*;
();

  localparam int          REC_W       = 6;
  localparam int          STIM_RECS   = 64;
  localparam int          WAIT_LIMIT  = 200;
  localparam int          DRAIN_LIMIT = 2000;
  localparam int unsigned SEED        = 32'haf6c174f;

  logic        clk;
  logic        rst;
  bus_req_t    bus_req;
  logic        bus_stb;
  logic        bus_cyc;
  logic        bus_stall;
  logic        bus_ack;
  bus_rsp_t    bus_rsp;

  logic [31:0] stim [REC_W * STIM_RECS];
  bus_rsp_t    exp_q [$];
  int          err_cnt;
  int          sent_cnt;
  int          acc_cnt;
  int          ack_cnt;
  int          stall_cnt;

  tb_clock tb_clock_inst (
    .clk_o (clk),
    .rst_o (rst)
  );

  cache_top cache_top_inst (
    .clk         (clk),
    .rst         (rst),
    .bus_req_i   (bus_req),
    .bus_stb_i   (bus_stb),
    .bus_cyc_i   (bus_cyc),
    .bus_stall_o (bus_stall),
    .bus_ack_o   (bus_ack),
    .bus_rsp_o   (bus_rsp)
  );

  task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
    begin
      if (got.dat !== exp.dat)
      begin
        $display("MISMATCH %s.dat: got %h, expected %h", name, got.dat, exp.dat);
        err_cnt++;
      end
      if (got.tag !== exp.tag)
      begin
        $display("MISMATCH %s.tag: got %h, expected %h", name, got.tag, exp.tag);
        err_cnt++;
      end
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    begin
      if (got != exp)
      begin
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        err_cnt++;
      end
    end
  endtask

  // Line i of a sweep, word chosen by i mod 4.
  function automatic logic [31:0] sweep_addr(input logic [31:0] base, input int i);
    return base + 32'(i) * 32'h10 + 32'(i % 4) * 32'h4;
  endfunction

  function automatic logic [31:0] sweep_word(input logic [31:0] adr);
    return {~adr[15:0], adr[15:0]};
  endfunction

  // Sampled at the falling edge, taken at the next rising edge.
  always @(negedge clk)
  begin
    bus_rsp_t exp;
    if (!rst)
    begin
      if (bus_cyc && bus_stb && !bus_stall)
        acc_cnt++;
      if (bus_cyc && bus_stb && bus_stall)
        stall_cnt++;
      if (bus_ack)
      begin
        ack_cnt++;
        if (exp_q.size() == 0)
        begin
          $display("Acknowledge seen with no request outstanding");
          err_cnt++;
        end
        else
        begin
          exp = exp_q.pop_front();
          check_rsp("bus_rsp_o", bus_rsp, exp);
        end
      end
      else
        check_rsp("bus_rsp_o without ack", bus_rsp, '0);
    end
  end

  task automatic drive_req(input bus_req_t req, input logic [31:0] exp_dat, output logic ok);
    int       waited;
    bus_rsp_t exp;
    begin
      waited  = 0;
      bus_req <= req;
      bus_stb <= 1'b1;
      bus_cyc <= 1'b1;
      @(negedge clk);
      while (bus_stall && waited < WAIT_LIMIT)
      begin
        @(negedge clk);
        waited++;
      end
      ok = !bus_stall;
      if (!ok)
      begin
        $display("Timeout: bus stall held for %0d cycles at address %h", WAIT_LIMIT, req.adr);
        err_cnt++;
      end
      else
      begin
        @(posedge clk);   // Accepted here.
        exp.dat = req.we ? '0 : exp_dat;
        exp.tag = req.tag;
        exp_q.push_back(exp);
        sent_cnt++;
      end
    end
  endtask

  task automatic idle_gap();
    int gap;
    begin
      gap = 1 + int'($urandom % 4);
      bus_stb <= 1'b0;
      bus_cyc <= 1'b0;
      repeat (gap) @(posedge clk);
    end
  endtask

  // Writes every line first, then reads them all back.
  task automatic sweep_lines(input logic [31:0] base, input int count, output logic ok);
    bus_req_t req;
    begin
      ok = 1'b1;
      for (int pass = 0; pass < 2; pass++)
      begin
        for (int i = 0; i < count && ok; i++)
        begin
          req.adr = sweep_addr(base, i);
          req.we  = (pass == 0);
          req.dat = req.we ? sweep_word(req.adr) : '0;
          req.sel = 4'hf;
          req.tag = bus_tag_t'(i[5:0]);
          drive_req(req, sweep_word(req.adr), ok);
          idle_gap();
        end
      end
    end
  endtask

  task automatic apply_record(input int rec, output logic ok);
    logic [31:0] op;
    bus_req_t    req;
    begin
      op = stim[rec * REC_W];
      if (op == 32'h2)
        sweep_lines(stim[rec * REC_W + 1], int'(stim[rec * REC_W + 2]), ok);
      else
      begin
        req.we  = op[0];
        req.adr = stim[rec * REC_W + 1];
        req.dat = stim[rec * REC_W + 2];
        req.sel = stim[rec * REC_W + 3][3:0];
        req.tag = bus_tag_t'(stim[rec * REC_W + 4][5:0]);
        drive_req(req, stim[rec * REC_W + 5], ok);
        if (ok && !op[4])
          idle_gap();   // Bit 4 keeps strobes back to back.
      end
    end
  endtask

  task automatic wait_drain(output logic ok);
    int waited;
    begin
      waited = 0;
      while (ack_cnt < acc_cnt && waited < DRAIN_LIMIT)
      begin
        @(negedge clk);
        waited++;
      end
      ok = (ack_cnt >= acc_cnt);
      if (!ok)
      begin
        $display("Timeout: only %0d of %0d requests acknowledged", ack_cnt, acc_cnt);
        err_cnt++;
      end
    end
  endtask

  initial
  begin
    int          rec;
    int          waited;
    logic        ok;
    bus_req   = '0;
    bus_stb   = 1'b0;
    bus_cyc   = 1'b0;
    err_cnt   = 0;
    sent_cnt  = 0;
    acc_cnt   = 0;
    ack_cnt   = 0;
    stall_cnt = 0;
    void'($urandom(SEED));
    $readmemh("tests/cache_stim.txt", stim);

    waited = 0;
    @(negedge clk);
    while (rst && waited < 10)
    begin
      @(negedge clk);
      waited++;
    end
    ok = !rst;
    if (!ok)
    begin
      $display("Timeout: reset never released");
      err_cnt++;
    end
    @(posedge clk);

    rec = 0;
    while (ok && rec < STIM_RECS && stim[rec * REC_W] != 32'hff)
    begin
      apply_record(rec, ok);
      rec++;
    end
    if (!ok)
      @(posedge clk);
    bus_stb <= 1'b0;
    bus_cyc <= 1'b0;

    if (ok && rec == STIM_RECS)
    begin
      $display("Stimulus file has no end record");
      err_cnt++;
    end
    if (ok)
    begin
      wait_drain(ok);
      repeat (4) @(negedge clk);   // Catch stray acks.
      check_count("bus_ack_o count", ack_cnt, acc_cnt);
      if (stall_cnt == 0)
      begin
        $display("Bus stall never rose during the back-to-back burst");
        err_cnt++;
      end
    end

    $display("Requests %0d, accepted %0d, acked %0d, stall cycles %0d, errors %0d",
             sent_cnt, acc_cnt, ack_cnt, stall_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic clk_o,
  output logic rst_o
);

  localparam int PERIOD     = 8;
  localparam int RST_CYCLES = 2;

  initial
  begin
    clk_o = 1'b0;
    forever
      #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;   // Released on an edge.
  end

endmodule

/* design/cache_top.sv */
`timescale 1ns/1ns

module cache_top
  import bus_pkg::*;
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  bus_req_t bus_req_i,
  input  logic     bus_stb_i,
  input  logic     bus_cyc_i,
  output logic     bus_stall_o,
  output logic     bus_ack_o,
  output bus_rsp_t bus_rsp_o
);

  bus_req_t   head_req;
  logic       head_empty;
  logic       head_pop;
  mem_req_t   mem_req;
  logic       mem_stb;
  logic       mem_stall;
  logic       mem_ack;
  line_data_t mem_rdata;

  req_fifo #(
    .payload_t   (bus_req_t),
    .DEPTH       (REQ_FIFO_DEPTH),
    .ALMOST_FULL (REQ_FIFO_ALMOST_FULL)
  ) req_fifo_inst (
    .clk           (clk),
    .rst           (rst),
    .push_i        (bus_cyc_i & bus_stb_i & ~bus_stall_o),
    .data_i        (bus_req_i),
    .pop_i         (head_pop),
    .data_o        (head_req),
    .empty_o       (head_empty),
    .almost_full_o (bus_stall_o)
  );

  line_cache line_cache_inst (
    .clk         (clk),
    .rst         (rst),
    .req_i       (head_req),
    .req_empty_i (head_empty),
    .req_pop_o   (head_pop),
    .ack_o       (bus_ack_o),
    .rsp_o       (bus_rsp_o),
    .mem_req_o   (mem_req),
    .mem_stb_o   (mem_stb),
    .mem_stall_i (mem_stall),
    .mem_ack_i   (mem_ack),
    .mem_rdata_i (mem_rdata)
  );

  line_store line_store_inst (
    .clk         (clk),
    .mem_req_i   (mem_req),
    .mem_stb_i   (mem_stb),
    .mem_stall_o (mem_stall),
    .mem_ack_o   (mem_ack),
    .mem_rdata_o (mem_rdata),
    .rst         (rst)
  );

endmodule

/* design/line_store.sv */
`timescale 1ns/1ns

module line_store
  import bus_pkg::*;
  import cache_pkg::*;
(
  input  logic       clk,
  input  mem_req_t   mem_req_i,
  input  logic       mem_stb_i,
  output logic       mem_stall_o,
  output logic       mem_ack_o,
  output line_data_t mem_rdata_o,
  input  logic       rst
);

  typedef logic [$clog2(STORE_RD_LATENCY)-1:0] lat_cnt_t;

  line_data_t               ram [2**STORE_DEPTH_W];
  logic [STORE_DEPTH_W-1:0] rd_addr;
  lat_cnt_t                 lat_cnt;
  logic                     busy;
  logic                     take;
  logic                     last;

  assign mem_stall_o = busy;
  assign take        = mem_stb_i & ~busy;
  assign last        = busy && (lat_cnt == lat_cnt_t'(1));

  initial
  begin
    for (int i = 0; i < 2**STORE_DEPTH_W; i++)
      ram[i] = '0;
  end

  always_ff @(posedge clk)
  begin
    if (take && mem_req_i.we)
      ram[mem_req_i.adr[STORE_DEPTH_W-1:0]] <= mem_req_i.dat;   // Writes land at once.
    if (take && !mem_req_i.we)
      rd_addr <= mem_req_i.adr[STORE_DEPTH_W-1:0];
    if (last)
      mem_rdata_o <= ram[rd_addr];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy      <= 1'b0;
      lat_cnt   <= '0;
      mem_ack_o <= 1'b0;
    end
    else
    begin
      mem_ack_o <= last;
      if (take && !mem_req_i.we)
      begin
        busy    <= 1'b1;
        lat_cnt <= lat_cnt_t'(STORE_RD_LATENCY - 1);
      end
      else if (busy)
      begin
        lat_cnt <= lat_cnt - 1'b1;
        if (last)
          busy <= 1'b0;   // Stall drops in the ack cycle.
      end
    end
  end

endmodule

/* cache/line_cache.sv */
`timescale 1ns/1ns

module line_cache
  import bus_pkg::*;
  import cache_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  bus_req_t   req_i,
  input  logic       req_empty_i,
  output logic       req_pop_o,
  output logic       ack_o,
  output bus_rsp_t   rsp_o,
  output mem_req_t   mem_req_o,
  output logic       mem_stb_o,
  input  logic       mem_stall_i,
  input  logic       mem_ack_i,
  input  line_data_t mem_rdata_i
);

  typedef struct packed {
    logic idle;
    logic flush;
    logic load;
    logic load_pend;
    logic update;
  } state_t;

  state_t state;

  logic [LINE_COUNT-1:0] line_vld;
  logic [LINE_COUNT-1:0] line_dirty;
  logic [LINE_TAG_W-1:0] line_tag  [LINE_COUNT];
  line_data_t            line_data [LINE_COUNT];

  line_idx_t             entry;     // Line in use by the head request.
  logic                  touch;
  line_idx_t             lru_idx;

  logic [LINE_TAG_W-1:0] req_tag;
  logic                  hit;
  line_idx_t             hit_idx;
  line_idx_t             victim;
  logic [BUS_DAT_W-1:0]  cur_word;
  logic [BUS_DAT_W-1:0]  rd_word;
  mem_req_t              load_req;

  assign req_tag   = req_i.adr[4 +: LINE_TAG_W];
  assign load_req  = '{adr: req_tag, dat: '0, we: 1'b0};
  assign req_pop_o = state.update;   // Head is done at the end of update.

  lru_tracker lru_tracker_inst (
    .clk         (clk),
    .rst         (rst),
    .touch_i     (touch),
    .touch_idx_i (entry),
    .lru_idx_o   (lru_idx)
  );

  always_comb
  begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < LINE_COUNT; i++)
    begin
      if (line_vld[i] && line_tag[i] == req_tag)
      begin
        hit     = 1'b1;
        hit_idx = line_idx_t'(i);
      end
    end
  end

  // Lowest free line wins over the LRU line.
  always_comb
  begin
    victim = lru_idx;
    for (int i = LINE_COUNT - 1; i >= 0; i--)
    begin
      if (!line_vld[i])
        victim = line_idx_t'(i);
    end
  end

  always_comb
  begin
    cur_word = line_data[entry][req_i.adr[3:2] * BUS_DAT_W +: BUS_DAT_W];
    for (int b = 0; b < BUS_DAT_W / 8; b++)
      rd_word[b*8 +: 8] = req_i.sel[b] ? cur_word[b*8 +: 8] : 8'h00;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= '{idle: 1'b1, default: 1'b0};
      line_vld   <= '0;
      line_dirty <= '0;
      entry      <= '0;
      touch      <= 1'b0;
      ack_o      <= 1'b0;
      rsp_o      <= '0;
      mem_stb_o  <= 1'b0;
    end
    else
    begin
      touch <= 1'b0;
      ack_o <= 1'b0;
      rsp_o <= '0;
      unique case (1'b1)
        state.idle:
        begin
          if (!req_empty_i)
          begin
            touch <= 1'b1;
            if (hit)
            begin
              entry <= hit_idx;
              state <= '{update: 1'b1, default: 1'b0};
            end
            else
            begin
              entry     <= victim;
              mem_stb_o <= 1'b1;
              if (line_vld[victim] && line_dirty[victim])
              begin
                mem_req_o <= '{adr: line_tag[victim], dat: line_data[victim], we: 1'b1};
                state     <= '{flush: 1'b1, default: 1'b0};
              end
              else
              begin
                mem_req_o <= load_req;
                state     <= '{load: 1'b1, default: 1'b0};
              end
            end
          end
        end
        state.flush:
        begin
          if (!mem_stall_i)
          begin
            mem_req_o <= load_req;   // Write-back taken, fetch follows.
            state     <= '{load: 1'b1, default: 1'b0};
          end
        end
        state.load:
        begin
          line_vld[entry]   <= 1'b0;
          line_dirty[entry] <= 1'b0;
          line_tag[entry]   <= req_tag;
          if (!mem_stall_i)
          begin
            mem_stb_o <= 1'b0;
            state     <= '{load_pend: 1'b1, default: 1'b0};
          end
        end
        state.load_pend:
        begin
          if (mem_ack_i)
          begin
            line_data[entry] <= mem_rdata_i;
            line_vld[entry]  <= 1'b1;
            state            <= '{update: 1'b1, default: 1'b0};
          end
        end
        state.update:
        begin
          if (req_i.we)
          begin
            line_dirty[entry] <= 1'b1;
            for (int b = 0; b < BUS_DAT_W / 8; b++)
            begin
              if (req_i.sel[b])
                line_data[entry][req_i.adr[3:2] * BUS_DAT_W + b*8 +: 8] <= req_i.dat[b*8 +: 8];
            end
          end
          else
          begin
            rsp_o.dat <= rd_word;   // Write acks carry no data.
          end
          rsp_o.tag <= req_i.tag;
          ack_o     <= 1'b1;
          state     <= '{idle: 1'b1, default: 1'b0};
        end
        default: state <= '{idle: 1'b1, default: 1'b0};
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("line_cache: state not one-hot %b", state);

  // A stalled request must stay put until the store takes it.
  assert property (@(posedge clk) disable iff (rst)
                   mem_stb_o && mem_stall_i |=> mem_stb_o && $stable(mem_req_o))
    else $error("line_cache: memory request changed while stalled");

endmodule

/* cache/lru_tracker.sv */
`timescale 1ns/1ns

module lru_tracker
  import cache_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      touch_i,
  input  line_idx_t touch_idx_i,
  output line_idx_t lru_idx_o
);

  // Age zero is the most recent line.
  line_idx_t age [LINE_COUNT];
  line_idx_t touch_age;
  line_idx_t oldest_age;

  assign touch_age = age[touch_idx_i];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < LINE_COUNT; i++)
        age[i] <= line_idx_t'(i);   // Line 31 goes first.
    end
    else if (touch_i)
    begin
      for (int i = 0; i < LINE_COUNT; i++)
      begin
        if (line_idx_t'(i) == touch_idx_i)
          age[i] <= '0;
        else if (age[i] < touch_age)
          age[i] <= age[i] + 1'b1;   // Only younger lines move back.
      end
    end
  end

  // Strict compare keeps the lowest index on ties.
  always_comb
  begin
    lru_idx_o  = '0;
    oldest_age = age[0];
    for (int i = 1; i < LINE_COUNT; i++)
    begin
      if (age[i] > oldest_age)
      begin
        oldest_age = age[i];
        lru_idx_o  = line_idx_t'(i);
      end
    end
  end

endmodule

/* cache/req_fifo.sv */
`timescale 1ns/1ns

module req_fifo #(
  parameter type payload_t   = logic,
  parameter int  DEPTH       = 8,
  parameter int  ALMOST_FULL = 6
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     almost_full_o
);

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  payload_t slots [DEPTH];
  ptr_t     wr_ptr;
  ptr_t     rd_ptr;
  cnt_t     count;

  function automatic ptr_t next_ptr(ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign data_o        = slots[rd_ptr];   // Head is visible while not empty.
  assign empty_o       = (count == '0);
  assign almost_full_o = (count >= cnt_t'(ALMOST_FULL));

  always_ff @(posedge clk)
  begin
    if (push_i)
      slots[wr_ptr] <= data_i;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop_i)
        rd_ptr <= next_ptr(rd_ptr);
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (rst) push_i |-> (count < cnt_t'(DEPTH)))
    else $error("req_fifo: push while full");

  // The cache side must wait for a head entry.
  assert property (@(posedge clk) disable iff (rst) pop_i |-> !empty_o)
    else $error("req_fifo: pop while empty");

endmodule

/* common/bus_pkg.sv */
package bus_pkg;

  localparam int BUS_ADR_W = 32;
  localparam int BUS_DAT_W = 32;

  // Echoed back unchanged with the response.
  typedef struct packed {
    logic       tga;
    logic       tgd;
    logic [3:0] tgc;
  } bus_tag_t;

  typedef struct packed {
    logic [BUS_ADR_W-1:0] adr;
    logic [BUS_DAT_W-1:0] dat;
    logic                 we;
    logic [3:0]           sel;
    bus_tag_t             tag;
  } bus_req_t;

  typedef struct packed {
    logic [BUS_DAT_W-1:0] dat;
    bus_tag_t             tag;
  } bus_rsp_t;

  typedef struct packed {
    logic [cache_pkg::LINE_TAG_W-1:0] adr;   // Line address.
    cache_pkg::line_data_t            dat;
    logic                             we;
  } mem_req_t;

endpackage

/* common/cache_pkg.sv */
package cache_pkg;

  localparam int LINE_COUNT = 32;
  localparam int LINE_IDX_W = 5;

  localparam int LINE_W     = 128;
  localparam int LINE_TAG_W = 22;   // Address bits 25 to 4.

  typedef logic [LINE_IDX_W-1:0] line_idx_t;
  typedef logic [LINE_W-1:0]     line_data_t;

  localparam int REQ_FIFO_DEPTH       = 8;
  localparam int REQ_FIFO_ALMOST_FULL = 6;

  // Store covers 16 KiB of lines.
  localparam int STORE_DEPTH_W    = 10;
  localparam int STORE_RD_LATENCY = 4;

endpackage
